//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mul_tb
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- mul_chk.sv
module mul_chk (
  input logic                   Clk,
  input logic                   arst_n,
  input wallace_pkg::axil_req_t axil_req,
  input wallace_pkg::axil_rsp_t axil_rsp,
  input logic                   start,
  input logic                   product_valid
);

  localparam int DEPTH = wallace_pkg::PIPE_DEPTH;

  int fail_count = 0;

  // write response held until taken
  assert property (@(posedge Clk) disable iff (!arst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else begin
      $error("write response dropped or changed before bready");
      fail_count++;
    end

  assert property (@(posedge Clk) disable iff (!arst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else begin
      $error("read response dropped or changed before rready");
      fail_count++;
    end

  // fixed latency through the tree in both directions
  assert property (@(posedge Clk) disable iff (!arst_n)
    product_valid == $past(start, DEPTH))
    else begin
      $error("product_valid does not follow start by the pipeline depth");
      fail_count++;
    end

endmodule

bind mul_regs mul_chk u_chk (
  .Clk           (Clk),
  .arst_n        (arst_n),
  .axil_req      (axil_req),
  .axil_rsp      (axil_rsp),
  .start         (start),
  .product_valid (product_valid)
);

//--- mul_golden.txt
// columns: multiplier multiplicand expected_product
// all values in hex, unsigned
0000 0000 00000000
0000 ffff 00000000
0001 0001 00000001
0001 ffff 0000ffff
ffff 0001 0000ffff
ffff ffff fffe0001
8000 8000 40000000
0001 8000 00008000
0100 0010 00001000
0400 0020 00008000
8000 ffff 7fff8000
1234 5678 06260060
00ff 00ff 0000fe01
abcd 0002 0001579a
0003 0005 0000000f
7fff 7fff 3fff0001
c350 0002 000186a0

//--- mul_regs.sv
module mul_regs (
  input  logic                              Clk,
  input  logic                              arst_n,
  input  wallace_pkg::axil_req_t            axil_req,
  output wallace_pkg::axil_rsp_t            axil_rsp,
  output logic                              start,
  output logic [wallace_pkg::OPERAND_W-1:0] multiplier,
  output logic [wallace_pkg::OPERAND_W-1:0] multiplicand,
  input  logic [wallace_pkg::PRODUCT_W-1:0] product,
  input  logic                              product_valid
);

  localparam int DATA_W    = wallace_pkg::DATA_W;
  localparam int OPERAND_W = wallace_pkg::OPERAND_W;

  logic                              bvalid;
  logic [1:0]                        bresp;
  logic                              rvalid;
  logic [DATA_W-1:0]                 rdata;
  logic [1:0]                        rresp;
  logic                              done;
  logic [wallace_pkg::PRODUCT_W-1:0] result;

  logic              wr_fire;
  logic              rd_fire;
  logic              wr_ok;
  logic              ctrl_go;
  logic [DATA_W-1:0] rd_data_nxt;
  logic [1:0]        rd_resp_nxt;

  // one outstanding response per channel
  assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_fire = axil_req.arvalid & ~rvalid;

  assign ctrl_go = wr_fire & (axil_req.awaddr == wallace_pkg::ADDR_CTRL)
                 & axil_req.wstrb[0] & axil_req.wdata[0];

  // only operands and ctrl are writable
  always_comb begin
    case (axil_req.awaddr)
      wallace_pkg::ADDR_MULTIPLIER,
      wallace_pkg::ADDR_MULTIPLICAND,
      wallace_pkg::ADDR_CTRL: wr_ok = 1'b1;
      default:                wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rd_data_nxt = '0;
    rd_resp_nxt = wallace_pkg::RESP_OKAY;
    case (axil_req.araddr)
      wallace_pkg::ADDR_MULTIPLIER:   rd_data_nxt = {{(DATA_W-OPERAND_W){1'b0}}, multiplier};
      wallace_pkg::ADDR_MULTIPLICAND: rd_data_nxt = {{(DATA_W-OPERAND_W){1'b0}}, multiplicand};
      wallace_pkg::ADDR_CTRL:         rd_data_nxt = '0;
      wallace_pkg::ADDR_STATUS:       rd_data_nxt = {{(DATA_W-1){1'b0}}, done};
      wallace_pkg::ADDR_RESULT:       rd_data_nxt = result;
      default:                        rd_resp_nxt = wallace_pkg::RESP_SLVERR;
    endcase
  end

  // operand registers, byte strobes honored
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      multiplier   <= '0;
      multiplicand <= '0;
    end else if (wr_fire) begin
      for (int b = 0; b < OPERAND_W / 8; b++) begin
        if (axil_req.wstrb[b]) begin
          if (axil_req.awaddr == wallace_pkg::ADDR_MULTIPLIER) begin
            multiplier[8*b +: 8] <= axil_req.wdata[8*b +: 8];
          end
          if (axil_req.awaddr == wallace_pkg::ADDR_MULTIPLICAND) begin
            multiplicand[8*b +: 8] <= axil_req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      start  <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      start <= ctrl_go;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end
      // a new start wins over a product still draining
      if (ctrl_go) begin
        done <= 1'b0;
      end else if (product_valid) begin
        done <= 1'b1;
      end
      if (product_valid) begin
        result <= product;
      end
    end
  end

  // response payload, held until the handshake
  always_ff @(posedge Clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? wallace_pkg::RESP_OKAY : wallace_pkg::RESP_SLVERR;
    end
    if (rd_fire) begin
      rdata <= rd_data_nxt;
      rresp <= rd_resp_nxt;
    end
  end

  always_comb begin
    axil_rsp.awready = ~bvalid;
    axil_rsp.wready  = ~bvalid;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = ~rvalid;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
  end

endmodule

//--- mul_tb.sv
module mul_tb;

  localparam int MAX_CASES = 32;
  localparam int WAIT_MAX  = 40;

  logic                   Clk;
  logic                   arst_n;
  wallace_pkg::axil_req_t req;
  wallace_pkg::axil_rsp_t rsp;

  // three words per case for multiplier multiplicand and product
  logic [31:0] golden [0:3*MAX_CASES-1];
  logic [31:0] lfsr;
  int          num_cases;
  int          errors;
  int          cycles;
  int          cycle_limit;

  mul_top uut (
    .Clk      (Clk),
    .arst_n   (arst_n),
    .axil_req (req),
    .axil_rsp (rsp)
  );

  initial Clk = 1'b0;
  always #10 Clk = ~Clk;

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // two bits give 0 to 3 cycles of back-pressure
  task automatic random_delay(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      n = 2 * n + int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int delay;
    int waited;
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    req.wstrb   <= 4'hf;
    waited = 0;
    @(posedge Clk);
    while (!(rsp.awready && rsp.wready) && waited < WAIT_MAX) begin
      @(posedge Clk);
      waited++;
    end
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    if (waited >= WAIT_MAX) begin
      $display("write to address %h was never accepted by the DUT", addr);
      errors++;
    end
    random_delay(delay);
    repeat (delay) @(posedge Clk);
    req.bready <= 1'b1;
    waited = 0;
    @(posedge Clk);
    while (!rsp.bvalid && waited < WAIT_MAX) begin
      @(posedge Clk);
      waited++;
    end
    resp = rsp.bresp;
    req.bready <= 1'b0;
    if (waited >= WAIT_MAX) begin
      $display("write to address %h never got a response from the DUT", addr);
      errors++;
    end
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int delay;
    int waited;
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    waited = 0;
    @(posedge Clk);
    while (!rsp.arready && waited < WAIT_MAX) begin
      @(posedge Clk);
      waited++;
    end
    req.arvalid <= 1'b0;
    if (waited >= WAIT_MAX) begin
      $display("read from address %h was never accepted by the DUT", addr);
      errors++;
    end
    random_delay(delay);
    repeat (delay) @(posedge Clk);
    req.rready <= 1'b1;
    waited = 0;
    @(posedge Clk);
    while (!rsp.rvalid && waited < WAIT_MAX) begin
      @(posedge Clk);
      waited++;
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    req.rready <= 1'b0;
    if (waited >= WAIT_MAX) begin
      $display("read from address %h never got a response from the DUT", addr);
      errors++;
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] kept;
    logic [1:0]  resp;
    int          polls;
    lfsr    = 32'h1f7f_23e3;
    errors  = 0;
    cycles  = 0;
    req    <= '0;
    arst_n <= 1'b0;
    // unused slots carry a marker above the 16-bit operand range
    for (int i = 0; i < 3 * MAX_CASES; i++) begin
      golden[i] = {16'hdead, i[15:0]};
    end
    $readmemh("mul_golden.txt", golden);
    num_cases = 0;
    while (num_cases < MAX_CASES && golden[3*num_cases][31:16] == 16'h0000) begin
      num_cases++;
    end
    cycle_limit = 100 + 60 * num_cases;
    repeat (5) @(posedge Clk);
    arst_n <= 1'b1;
    @(posedge Clk);

    write_reg(wallace_pkg::ADDR_MULTIPLIER, 32'habcd_1234, resp);
    check_value("multiplier write resp", {30'b0, wallace_pkg::RESP_OKAY}, {30'b0, resp});
    write_reg(wallace_pkg::ADDR_MULTIPLICAND, 32'h5a5a_f00d, resp);
    check_value("multiplicand write resp", {30'b0, wallace_pkg::RESP_OKAY}, {30'b0, resp});
    read_reg(wallace_pkg::ADDR_MULTIPLIER, data, resp);
    check_value("multiplier readback", 32'h0000_1234, data);
    check_value("multiplier read resp", {30'b0, wallace_pkg::RESP_OKAY}, {30'b0, resp});
    read_reg(wallace_pkg::ADDR_MULTIPLICAND, data, resp);
    check_value("multiplicand readback", 32'h0000_f00d, data);
    check_value("multiplicand read resp", {30'b0, wallace_pkg::RESP_OKAY}, {30'b0, resp});

    for (int c = 0; c < num_cases; c++) begin
      write_reg(wallace_pkg::ADDR_MULTIPLIER, golden[3*c], resp);
      write_reg(wallace_pkg::ADDR_MULTIPLICAND, golden[3*c+1], resp);
      write_reg(wallace_pkg::ADDR_CTRL, 32'h1, resp);
      // still inside the pipeline latency here
      read_reg(wallace_pkg::ADDR_STATUS, data, resp);
      check_value($sformatf("case %0d status busy", c), 32'h0, data);
      polls = 0;
      while (data[0] !== 1'b1 && polls < 20) begin
        read_reg(wallace_pkg::ADDR_STATUS, data, resp);
        polls++;
      end
      check_value($sformatf("case %0d status done", c), 32'h1, data);
      read_reg(wallace_pkg::ADDR_RESULT, data, resp);
      check_value($sformatf("case %0d product", c), golden[3*c+2], data);
    end

    read_reg(wallace_pkg::ADDR_RESULT, kept, resp);
    write_reg(wallace_pkg::ADDR_RESULT, 32'h1234_5678, resp);
    check_value("result write resp", {30'b0, wallace_pkg::RESP_SLVERR}, {30'b0, resp});
    write_reg(8'h14, 32'h0000_0001, resp);
    check_value("unmapped write resp", {30'b0, wallace_pkg::RESP_SLVERR}, {30'b0, resp});
    read_reg(8'h14, data, resp);
    check_value("unmapped read resp", {30'b0, wallace_pkg::RESP_SLVERR}, {30'b0, resp});
    read_reg(wallace_pkg::ADDR_RESULT, data, resp);
    check_value("result unchanged", kept, data);

    errors += uut.u_regs.u_chk.fail_count;
    $display("run complete, %0d cases, error count %0d", num_cases, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  always @(posedge Clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout, the run did not end within %0d cycles", cycle_limit);
      $display("error count %0d", errors + uut.u_regs.u_chk.fail_count + 1);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

//--- mul_top.sv
module mul_top (
  input  logic                   Clk,
  input  logic                   arst_n,
  input  wallace_pkg::axil_req_t axil_req,
  output wallace_pkg::axil_rsp_t axil_rsp
);

  localparam int WIDTH = wallace_pkg::OPERAND_W;

  logic                 start;
  logic [WIDTH-1:0]     multiplier;
  logic [WIDTH-1:0]     multiplicand;
  logic [2*WIDTH-1:0]   product;
  logic                 product_valid;

  // bus side
  mul_regs u_regs (
    .Clk           (Clk),
    .arst_n        (arst_n),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .start         (start),
    .multiplier    (multiplier),
    .multiplicand  (multiplicand),
    .product       (product),
    .product_valid (product_valid)
  );

  // pipelined tree
  wallace_mult #(
    .WIDTH (WIDTH)
  ) u_mult (
    .Clk           (Clk),
    .arst_n        (arst_n),
    .start         (start),
    .multiplier    (multiplier),
    .multiplicand  (multiplicand),
    .product       (product),
    .product_valid (product_valid)
  );

endmodule

//--- partial_products.sv
module partial_products #(
  parameter int WIDTH = 16
) (
  input  logic                           Clk,
  input  logic                           arst_n,
  input  logic [WIDTH-1:0]               multiplier,
  input  logic [WIDTH-1:0]               multiplicand,
  output logic [WIDTH-1:0][2*WIDTH-1:0] rows
);

  localparam int ROW_W = 2 * WIDTH;

  logic [WIDTH-1:0][ROW_W-1:0] rows_d;

  // one row per multiplier bit, already at its weight
  always_comb begin
    for (int i = 0; i < WIDTH; i++) begin
      rows_d[i] = {{WIDTH{1'b0}}, multiplicand & {WIDTH{multiplier[i]}}} << i;
    end
  end

  // first pipeline stage
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      rows <= '0;
    end else begin
      rows <= rows_d;
    end
  end

endmodule

//--- project.f
wallace_pkg.sv
partial_products.sv
wallace_stage.sv
wallace_mult.sv
mul_regs.sv
mul_top.sv
mul_chk.sv
mul_tb.sv

//--- wallace_mult.sv
module wallace_mult #(
  parameter int WIDTH = 16
) (
  input  logic                 Clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic [WIDTH-1:0]     multiplier,
  input  logic [WIDTH-1:0]     multiplicand,
  output logic [2*WIDTH-1:0]   product,
  output logic                 product_valid
);

  localparam int ROW_W = 2 * WIDTH;
  localparam int DEPTH = wallace_pkg::PIPE_DEPTH;

  // row count entering each level
  localparam int R0 = WIDTH;
  localparam int R1 = wallace_pkg::tree_rows(WIDTH, 1);
  localparam int R2 = wallace_pkg::tree_rows(WIDTH, 2);
  localparam int R3 = wallace_pkg::tree_rows(WIDTH, 3);
  localparam int R4 = wallace_pkg::tree_rows(WIDTH, 4);
  localparam int R5 = wallace_pkg::tree_rows(WIDTH, 5);
  localparam int R6 = wallace_pkg::tree_rows(WIDTH, wallace_pkg::TREE_LEVELS);

  logic [R0-1:0][ROW_W-1:0] pp_rows;
  logic [R1-1:0][ROW_W-1:0] l1_rows;
  logic [R2-1:0][ROW_W-1:0] l2_rows;
  logic [R3-1:0][ROW_W-1:0] l3_rows;
  logic [R3-1:0][ROW_W-1:0] l3_q;
  logic [R4-1:0][ROW_W-1:0] l4_rows;
  logic [R5-1:0][ROW_W-1:0] l5_rows;
  logic [R6-1:0][ROW_W-1:0] l6_rows;
  logic [R6-1:0][ROW_W-1:0] l6_q;
  logic [DEPTH-1:0]         valid_sr;

  partial_products #(.WIDTH(WIDTH)) u_pp (
    .Clk          (Clk),
    .arst_n       (arst_n),
    .multiplier   (multiplier),
    .multiplicand (multiplicand),
    .rows         (pp_rows)
  );

  wallace_stage #(.WIDTH(WIDTH), .ROWS_IN(R0)) u_lvl1 (.rows_in(pp_rows), .rows_out(l1_rows));
  wallace_stage #(.WIDTH(WIDTH), .ROWS_IN(R1)) u_lvl2 (.rows_in(l1_rows), .rows_out(l2_rows));
  wallace_stage #(.WIDTH(WIDTH), .ROWS_IN(R2)) u_lvl3 (.rows_in(l2_rows), .rows_out(l3_rows));

  // second cut, after level 3
  always_ff @(posedge Clk) begin
    l3_q <= l3_rows;
  end

  wallace_stage #(.WIDTH(WIDTH), .ROWS_IN(R3)) u_lvl4 (.rows_in(l3_q), .rows_out(l4_rows));
  wallace_stage #(.WIDTH(WIDTH), .ROWS_IN(R4)) u_lvl5 (.rows_in(l4_rows), .rows_out(l5_rows));
  wallace_stage #(.WIDTH(WIDTH), .ROWS_IN(R5)) u_lvl6 (.rows_in(l5_rows), .rows_out(l6_rows));

  // last two rows, then the carry-propagate add
  always_ff @(posedge Clk) begin
    l6_q    <= l6_rows;
    product <= l6_q[0] + l6_q[1];
  end

  // valid runs alongside the data, no stall
  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[DEPTH-2:0], start};
    end
  end

  assign product_valid = valid_sr[DEPTH-1];

endmodule

//--- wallace_pkg.sv
package wallace_pkg;

  // multiplier geometry
  localparam int OPERAND_W   = 16;
  localparam int PRODUCT_W   = 2 * OPERAND_W;
  localparam int TREE_LEVELS = 6;
  localparam int PIPE_DEPTH  = 4;

  // bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // register map, byte offsets
  localparam logic [ADDR_W-1:0] ADDR_MULTIPLIER   = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_MULTIPLICAND = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_CTRL         = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_STATUS       = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_RESULT       = 8'h10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  // rows left after a number of 3:2 levels
  function automatic int tree_rows(int rows, int levels);
    int n;
    n = rows;
    for (int l = 0; l < levels; l++) begin
      n = 2 * (n / 3) + n % 3;
    end
    return n;
  endfunction

endpackage

//--- wallace_stage.sv
module wallace_stage #(
  parameter int WIDTH   = 16,
  parameter int ROWS_IN = 16,
  localparam int ROWS_OUT = wallace_pkg::tree_rows(ROWS_IN, 1)
) (
  input  logic [ROWS_IN-1:0][2*WIDTH-1:0]  rows_in,
  output logic [ROWS_OUT-1:0][2*WIDTH-1:0] rows_out
);

  localparam int ROW_W  = 2 * WIDTH;
  localparam int GROUPS = ROWS_IN / 3;
  localparam int LEFT   = ROWS_IN % 3;

  // each triple of rows through a row of full adders
  for (genvar g = 0; g < GROUPS; g++) begin : g_csa
    logic [ROW_W-1:0] a;
    logic [ROW_W-1:0] b;
    logic [ROW_W-1:0] c;
    logic [ROW_W-1:0] sum;
    logic [ROW_W-2:0] cy;

    assign a = rows_in[3*g];
    assign b = rows_in[3*g+1];
    assign c = rows_in[3*g+2];

    // column sums
    assign sum = a ^ b ^ c;

    // carry out of the top column falls off, the product fits in ROW_W bits
    assign cy = (a[ROW_W-2:0] & b[ROW_W-2:0])
              | (a[ROW_W-2:0] & c[ROW_W-2:0])
              | (b[ROW_W-2:0] & c[ROW_W-2:0]);

    assign rows_out[2*g]   = sum;
    assign rows_out[2*g+1] = {cy, 1'b0};
  end

  // one or two rows left over go straight through
  for (genvar p = 0; p < LEFT; p++) begin : g_pass
    assign rows_out[2*GROUPS+p] = rows_in[3*GROUPS+p];
  end

endmodule
